/* dv/axi_sram_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "axi_sram_defines.svh"

module axi_sram_tb;

  localparam int RESET_CYCLES = 16;
  localparam int N            = 8;   // transactions per loop
  localparam int TXNS         = 100; // all reads and writes below
  localparam int MAX_CYCLES   = RESET_CYCLES + 40 * TXNS;
  localparam int MEM_BYTES    = 4 << `SRAM_ADDR_BITS;

  logic                       aclk;
  logic                       areset;
  logic [`AXI_ADDR_WIDTH-1:0] araddr;
  logic                       arvalid;
  logic                       arready;
  logic [`AXI_DATA_WIDTH-1:0] rdata;
  axi_lite_pkg::axi_resp_t    rresp;
  logic                       rvalid;
  logic                       rready;
  logic [`AXI_ADDR_WIDTH-1:0] awaddr;
  logic                       awvalid;
  logic                       awready;
  logic [`AXI_DATA_WIDTH-1:0] wdata;
  logic [`AXI_STRB_WIDTH-1:0] wstrb;
  logic                       wvalid;
  logic                       wready;
  axi_lite_pkg::axi_resp_t    bresp;
  logic                       bvalid;
  logic                       bready;

  logic [7:0]              model [MEM_BYTES]; // byte image of the array
  logic [33:0]             r_exp [$];         // data over resp
  axi_lite_pkg::axi_resp_t b_exp [$];
  logic [31:0]             stim_lfsr = 32'hd47b_d0ee;
  logic [31:0]             stall_lfsr = 32'hd47b_d0ee;
  logic                    stall_en;
  logic                    r_stalled;
  logic [31:0]             r_held;
  int                      cycle_count = 0;

  axi_sram u_axi_sram (
    .aclk    (aclk),
    .areset  (areset),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready)
  );

  always #50 aclk = ~aclk;

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] stim_rand(input int nbits);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < nbits; i++) begin
      stim_lfsr = lfsr_next(stim_lfsr);
      r = {r[30:0], stim_lfsr[31]};
    end
    return r;
  endfunction

  function automatic logic stall_bit();
    stall_lfsr = lfsr_next(stall_lfsr);
    return stall_lfsr[31];
  endfunction

  function automatic logic [33:0] expected_read(input logic [31:0] addr);
    logic [31:0] word;
    logic [31:0] base;
    if (addr >= MEM_BYTES) return {32'h0, axi_lite_pkg::SLVERR}; // past the array
    base = {addr[31:2], 2'b00};
    for (int b = 0; b < 4; b++) word[8*b +: 8] = model[base + b];
    return {word, axi_lite_pkg::OKAY};
  endfunction

  function automatic axi_lite_pkg::axi_resp_t expected_bresp(input logic [31:0] addr);
    if (addr >= MEM_BYTES) return axi_lite_pkg::SLVERR;
    return axi_lite_pkg::OKAY;
  endfunction

  function automatic void model_write(input logic [31:0] addr, input logic [31:0] data,
                                      input logic [3:0] strb);
    logic [31:0] base;
    base = {addr[31:2], 2'b00};
    if (addr < MEM_BYTES) begin
      for (int b = 0; b < 4; b++) if (strb[b]) model[base + b] = data[8*b +: 8];
    end
  endfunction

  task automatic fail_run(input string why);
    $display("%s at %0t ns", why, $time);
    $display("*** FAILED ***");
    $fatal(1, "run stopped");
  endtask

  task automatic compare_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
    if (expected !== actual) begin
      $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
      $display("*** FAILED ***");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // called at a rising edge, returns at the R handshake edge
  task automatic read_txn(input logic [31:0] addr);
    arvalid <= 1'b1;
    araddr  <= addr;
    do @(posedge aclk); while (!arready);
    r_exp.push_back(expected_read(addr));
    arvalid <= 1'b0;
    do @(posedge aclk); while (!(rvalid && rready));
  endtask

  // w_lead > 0 puts W that many cycles ahead of AW, < 0 behind it
  task automatic write_txn(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input int w_lead);
    fork
      begin
        repeat (w_lead > 0 ? w_lead : 0) @(posedge aclk);
        awvalid <= 1'b1;
        awaddr  <= addr;
        do @(posedge aclk); while (!awready);
        awvalid <= 1'b0;
      end
      begin
        repeat (w_lead < 0 ? -w_lead : 0) @(posedge aclk);
        wvalid <= 1'b1;
        wdata  <= data;
        wstrb  <= strb;
        do @(posedge aclk); while (!wready);
        wvalid <= 1'b0;
      end
    join
    b_exp.push_back(expected_bresp(addr));
    model_write(addr, data, strb);
    do @(posedge aclk); while (!(bvalid && bready));
  endtask

  always @(posedge aclk) begin
    if (stall_en) begin
      rready <= stall_bit();
      bready <= stall_bit();
    end else begin
      rready <= 1'b1;
      bready <= 1'b1;
    end
  end

  // response checker, one entry per handshake
  always @(posedge aclk) begin
    logic [33:0] r_next;
    if (areset) begin
      r_stalled <= 1'b0;
    end else begin
      if (r_stalled) compare_value("rdata during stall", r_held, rdata);
      if (rvalid && rready) begin
        if (r_exp.size() == 0) begin
          fail_run("R response arrived with no read outstanding");
        end else begin
          r_next = r_exp.pop_front();
          compare_value("rdata", r_next[33:2], rdata);
          compare_value("rresp", r_next[1:0], rresp);
        end
      end
      if (bvalid && bready) begin
        if (b_exp.size() == 0) begin
          fail_run("B response arrived with no write outstanding");
        end else begin
          compare_value("bresp", b_exp.pop_front(), bresp);
        end
      end
      r_stalled <= rvalid && !rready;
      r_held    <= rdata;
    end
  end

  always @(posedge aclk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) fail_run("timed out waiting for the DUT");
  end

  initial begin
    logic [31:0] addr_tab [N];
    logic [31:0] hi_addr [N];
    logic [31:0] hi_data [N];
    logic [31:0] oor;
    aclk     = 1'b0;
    areset   = 1'b1;
    araddr   = '0;
    arvalid  = 1'b0;
    awaddr   = '0;
    awvalid  = 1'b0;
    wdata    = '0;
    wstrb    = '0;
    wvalid   = 1'b0;
    rready   = 1'b1;
    bready   = 1'b1;
    stall_en = 1'b0;
    repeat (RESET_CYCLES) @(posedge aclk);
    areset <= 1'b0;
    @(posedge aclk);
    compare_value("rvalid", 0, rvalid);
    compare_value("bvalid", 0, bvalid);
    compare_value("rresp", axi_lite_pkg::OKAY, rresp);
    compare_value("bresp", axi_lite_pkg::OKAY, bresp);
    @(posedge aclk);
    compare_value("arready", 1, arready);
    compare_value("awready", 1, awready);
    compare_value("wready", 1, wready);

    // full words into the lower half, then read back
    for (int i = 0; i < N; i++) begin
      addr_tab[i] = {20'h0, 1'b0, 9'(stim_rand(9)), 2'b00};
      write_txn(addr_tab[i], stim_rand(32), 4'hf, 0);
    end
    for (int i = 0; i < N; i++) read_txn(addr_tab[i]);

    // partial strobes
    for (int i = 0; i < N; i++) write_txn(addr_tab[i], stim_rand(32), 4'(stim_rand(4)), 0);
    for (int i = 0; i < N; i++) read_txn(addr_tab[i]);

    // out of range aliasing a live word
    for (int i = 0; i < 4; i++) begin
      oor = {20'(stim_rand(20)) | 20'h1, addr_tab[i][11:0]};
      write_txn(oor, stim_rand(32), 4'hf, 0);
      read_txn(oor);
      read_txn(addr_tab[i]);
    end

    // W ahead of, with, or behind AW
    for (int i = 0; i < N; i++) begin
      write_txn(addr_tab[i], stim_rand(32), 4'hf, int'(stim_rand(3)) - 3);
      read_txn(addr_tab[i]);
    end

    stall_en <= 1'b1;
    for (int i = 0; i < N; i++) begin
      write_txn(addr_tab[i], stim_rand(32), 4'(stim_rand(4)), 0);
      read_txn(addr_tab[i]);
    end

    // writes to the upper half race reads of the lower half
    for (int i = 0; i < N; i++) begin
      hi_addr[i] = {20'h0, 1'b1, 9'(stim_rand(9)), 2'b00};
      hi_data[i] = stim_rand(32);
    end
    fork
      for (int i = 0; i < N; i++) write_txn(hi_addr[i], hi_data[i], 4'hf, 0);
      for (int i = 0; i < N; i++) read_txn(addr_tab[i]);
    join
    for (int i = 0; i < N; i++) read_txn(hi_addr[i]);
    stall_en <= 1'b0;

    repeat (4) @(posedge aclk);
    if (r_exp.size() != 0 || b_exp.size() != 0) begin
      fail_run("responses still outstanding at end of test");
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* files.f */
+incdir+source
source/axi_lite_pkg.sv
source/sram_pkg.sv
source/sram_port_if.sv
source/axi_resp_slot.sv
source/axi_read_engine.sv
source/axi_write_engine.sv
source/sram_port_arbiter.sv
source/sram_array.sv
source/axi_sram.sv
dv/axi_sram_tb.sv

/* source/axi_lite_pkg.sv */
`default_nettype none
`include "axi_sram_defines.svh"

package axi_lite_pkg;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_t;

  // R channel payload, data over resp
  typedef struct packed {
    logic [`AXI_DATA_WIDTH-1:0] data;
    axi_resp_t                  resp;
  } axi_r_payload_t;

  typedef struct packed {
    axi_resp_t resp;
  } axi_b_payload_t;

endpackage

`default_nettype wire

/* source/axi_read_engine.sv */
`timescale 1ns/1ps
`default_nettype none
`include "axi_sram_defines.svh"

module axi_read_engine (
  input  wire                        aclk,
  input  wire                        areset,
  input  wire [`AXI_ADDR_WIDTH-1:0]  araddr,
  input  wire                        arvalid,
  output logic                       arready,
  output logic [`AXI_DATA_WIDTH-1:0] rdata,
  output axi_lite_pkg::axi_resp_t    rresp,
  output logic                       rvalid,
  input  wire                        rready,
  sram_port_if.master                mem
);

  typedef enum logic [1:0] {RD_IDLE, RD_WAIT_GNT, RD_WAIT_DATA} rd_state_t;

  rd_state_t                    state;
  logic [`AXI_ADDR_WIDTH-1:0]   addr_q;
  logic                         addr_ok;
  logic                         ar_fire;
  logic                         slot_load;
  axi_lite_pkg::axi_r_payload_t slot_in;
  axi_lite_pkg::axi_r_payload_t slot_out;

  assign ar_fire = arvalid && arready;
  assign addr_ok = addr_q[`AXI_ADDR_WIDTH-1:`SRAM_ADDR_BITS+2] == '0; // upper bits clear

  always_ff @(posedge aclk) begin
    if (ar_fire) addr_q <= araddr;
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      state   <= RD_IDLE;
      arready <= 1'b0;
    end else begin
      arready <= !ar_fire && state == RD_IDLE && (!rvalid || rready);
      case (state)
        RD_IDLE: if (ar_fire) state <= RD_WAIT_GNT;
        RD_WAIT_GNT: begin
          if (!addr_ok) state <= RD_IDLE; // SLVERR loaded this cycle
          else if (mem.gnt) state <= RD_WAIT_DATA;
        end
        RD_WAIT_DATA: if (mem.rvalid) state <= RD_IDLE;
        default: state <= RD_IDLE;
      endcase
    end
  end

  assign mem.req   = state == RD_WAIT_GNT && addr_ok;
  assign mem.we    = 1'b0;
  assign mem.index = addr_q[`SRAM_ADDR_BITS+1:2];
  assign mem.wdata = '0;
  assign mem.strb  = '0;

  always_comb begin
    slot_load    = 1'b0;
    slot_in.data = mem.rdata;
    slot_in.resp = axi_lite_pkg::OKAY;
    if (state == RD_WAIT_GNT && !addr_ok) begin
      slot_load    = 1'b1;
      slot_in.data = '0;
      slot_in.resp = axi_lite_pkg::SLVERR;
    end else if (state == RD_WAIT_DATA && mem.rvalid) begin
      slot_load = 1'b1;
    end
  end

  axi_resp_slot #(.payload_t(axi_lite_pkg::axi_r_payload_t)) u_r_slot (
    .aclk        (aclk),
    .areset      (areset),
    .in_valid    (slot_load),
    .in_payload  (slot_in),
    .out_valid   (rvalid),
    .out_ready   (rready),
    .out_payload (slot_out)
  );

  assign rdata = slot_out.data;
  assign rresp = slot_out.resp;

  a_rdata_stable: assert property (
    @(posedge aclk) disable iff (areset)
    rvalid && !rready |=> rvalid && $stable(rdata)
  );

endmodule

`default_nettype wire

/* source/axi_resp_slot.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_resp_slot #(
  parameter type payload_t = logic
) (
  input  wire      aclk,
  input  wire      areset,
  input  wire      in_valid,
  input  wire      payload_t in_payload,
  output logic     out_valid,
  input  wire      out_ready,
  output payload_t out_payload
);

  always_ff @(posedge aclk) begin
    if (areset) begin
      out_valid <= 1'b0;
    end else if (in_valid) begin
      out_valid <= 1'b1; // refill may coincide with drain
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  // zero payload shows OKAY out of reset
  always_ff @(posedge aclk) begin
    if (areset) begin
      out_payload <= '0;
    end else if (in_valid) begin
      out_payload <= in_payload;
    end
  end

  // engine only loads an empty or draining slot
  a_no_overrun: assert property (
    @(posedge aclk) disable iff (areset)
    in_valid |-> (!out_valid || out_ready)
  );

endmodule

`default_nettype wire

/* source/axi_sram.sv */
`timescale 1ns/1ps
`default_nettype none
`include "axi_sram_defines.svh"

module axi_sram (
  input  wire                        aclk,
  input  wire                        areset,
  input  wire [`AXI_ADDR_WIDTH-1:0]  araddr,
  input  wire                        arvalid,
  output logic                       arready,
  output logic [`AXI_DATA_WIDTH-1:0] rdata,
  output axi_lite_pkg::axi_resp_t    rresp,
  output logic                       rvalid,
  input  wire                        rready,
  input  wire [`AXI_ADDR_WIDTH-1:0]  awaddr,
  input  wire                        awvalid,
  output logic                       awready,
  input  wire [`AXI_DATA_WIDTH-1:0]  wdata,
  input  wire [`AXI_STRB_WIDTH-1:0]  wstrb,
  input  wire                        wvalid,
  output logic                       wready,
  output axi_lite_pkg::axi_resp_t    bresp,
  output logic                       bvalid,
  input  wire                        bready
);

  sram_port_if rd_port ();
  sram_port_if wr_port ();
  sram_port_if mem_port (); // arbiter to array

  axi_read_engine u_read_engine (
    .aclk    (aclk),
    .areset  (areset),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .mem     (rd_port.master)
  );

  axi_write_engine u_write_engine (
    .aclk    (aclk),
    .areset  (areset),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .mem     (wr_port.master)
  );

  sram_port_arbiter u_arbiter (
    .aclk   (aclk),
    .areset (areset),
    .rd     (rd_port.slave),
    .wr     (wr_port.slave),
    .mem    (mem_port.master)
  );

  sram_array u_array (
    .aclk   (aclk),
    .areset (areset),
    .port   (mem_port.mem)
  );

endmodule

`default_nettype wire

/* source/axi_sram_defines.svh */
`ifndef AXI_SRAM_DEFINES_SVH
`define AXI_SRAM_DEFINES_SVH

// AXI-Lite bus widths
`define AXI_ADDR_WIDTH 32
`define AXI_DATA_WIDTH 32
`define AXI_STRB_WIDTH 4

// scratch array geometry, 1024 words
`define SRAM_ADDR_BITS 10

// read latency in clocks, at least 1
`define SRAM_READ_CYCLE 1

`endif

/* source/axi_write_engine.sv */
`timescale 1ns/1ps
`default_nettype none
`include "axi_sram_defines.svh"

module axi_write_engine (
  input  wire                        aclk,
  input  wire                        areset,
  input  wire [`AXI_ADDR_WIDTH-1:0]  awaddr,
  input  wire                        awvalid,
  output logic                       awready,
  input  wire [`AXI_DATA_WIDTH-1:0]  wdata,
  input  wire [`AXI_STRB_WIDTH-1:0]  wstrb,
  input  wire                        wvalid,
  output logic                       wready,
  output axi_lite_pkg::axi_resp_t    bresp,
  output logic                       bvalid,
  input  wire                        bready,
  sram_port_if.master                mem
);

  logic [`AXI_ADDR_WIDTH-1:0]   addr_q;
  sram_pkg::sram_word_t         data_q;
  sram_pkg::sram_strb_t         strb_q;
  logic                         aw_held;
  logic                         w_held;
  logic                         aw_fire;
  logic                         w_fire;
  logic                         both_held;
  logic                         addr_ok;
  logic                         write_req;
  logic                         issue;
  logic                         b_free;
  axi_lite_pkg::axi_b_payload_t slot_in;
  axi_lite_pkg::axi_b_payload_t slot_out;

  assign aw_fire   = awvalid && awready;
  assign w_fire    = wvalid && wready;
  assign both_held = aw_held && w_held;
  assign addr_ok   = addr_q[`AXI_ADDR_WIDTH-1:`SRAM_ADDR_BITS+2] == '0;
  assign write_req = both_held && addr_ok && strb_q != '0; // empty mask skips the array
  assign issue     = both_held && (mem.gnt || !write_req);
  assign b_free    = !bvalid || bready;

  always_ff @(posedge aclk) begin
    if (aw_fire) addr_q <= awaddr;
    if (w_fire) begin
      data_q <= wdata;
      strb_q <= wstrb;
    end
  end

  // each phase captured on its own, order free
  always_ff @(posedge aclk) begin
    if (areset) begin
      aw_held <= 1'b0;
      w_held  <= 1'b0;
      awready <= 1'b0;
      wready  <= 1'b0;
    end else begin
      awready <= !aw_fire && !aw_held && b_free;
      wready  <= !w_fire && !w_held && b_free;
      if (aw_fire) aw_held <= 1'b1;
      else if (issue) aw_held <= 1'b0;
      if (w_fire) w_held <= 1'b1;
      else if (issue) w_held <= 1'b0;
    end
  end

  assign mem.req   = write_req;
  assign mem.we    = 1'b1;
  assign mem.index = addr_q[`SRAM_ADDR_BITS+1:2];
  assign mem.wdata = data_q;
  assign mem.strb  = strb_q;

  always_comb begin
    if (addr_ok) slot_in.resp = axi_lite_pkg::OKAY;
    else slot_in.resp = axi_lite_pkg::SLVERR;
  end

  axi_resp_slot #(.payload_t(axi_lite_pkg::axi_b_payload_t)) u_b_slot (
    .aclk        (aclk),
    .areset      (areset),
    .in_valid    (issue), // B loads in the grant cycle
    .in_payload  (slot_in),
    .out_valid   (bvalid),
    .out_ready   (bready),
    .out_payload (slot_out)
  );

  assign bresp = slot_out.resp;

  a_req_held: assert property (
    @(posedge aclk) disable iff (areset)
    mem.req && !mem.gnt |=> mem.req && $stable(mem.index) && $stable(mem.wdata)
      && $stable(mem.strb)
  );

endmodule

`default_nettype wire

/* source/sram_array.sv */
`timescale 1ns/1ps
`default_nettype none
`include "axi_sram_defines.svh"

module sram_array (
  input wire       aclk,
  input wire       areset,
  sram_port_if.mem port
);

  localparam int DEPTH = 1 << `SRAM_ADDR_BITS;
  localparam int LAT   = `SRAM_READ_CYCLE;

  sram_pkg::sram_word_t store [DEPTH];
  sram_pkg::sram_word_t data_pipe [LAT];
  logic [LAT-1:0]       vld_pipe;
  logic                 rd_fire;
  logic                 wr_fire;

  assign port.gnt = port.req; // always ready
  assign rd_fire  = port.req && port.gnt && !port.we;
  assign wr_fire  = port.req && port.gnt && port.we;

  always_ff @(posedge aclk) begin
    if (wr_fire) begin
      for (int b = 0; b < `AXI_STRB_WIDTH; b++) begin
        if (port.strb[b]) store[port.index][8*b +: 8] <= port.wdata[8*b +: 8];
      end
    end
    if (rd_fire) data_pipe[0] <= store[port.index];
    for (int i = 1; i < LAT; i++) data_pipe[i] <= data_pipe[i-1];
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe[0] <= rd_fire;
      for (int i = 1; i < LAT; i++) vld_pipe[i] <= vld_pipe[i-1];
    end
  end

  assign port.rvalid = vld_pipe[LAT-1];
  assign port.rdata  = data_pipe[LAT-1];

  a_read_latency: assert property (
    @(posedge aclk) disable iff (areset)
    rd_fire |-> ##LAT port.rvalid
  );

endmodule

`default_nettype wire

/* source/sram_pkg.sv */
`default_nettype none
`include "axi_sram_defines.svh"

package sram_pkg;

  typedef logic [`AXI_DATA_WIDTH-1:0] sram_word_t;

  // word index, byte address without the low two bits
  typedef logic [`SRAM_ADDR_BITS-1:0] sram_index_t;

  typedef logic [`AXI_STRB_WIDTH-1:0] sram_strb_t;

endpackage

`default_nettype wire

/* source/sram_port_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_port_arbiter (
  input  wire         aclk,
  input  wire         areset,
  sram_port_if.slave  rd,
  sram_port_if.slave  wr,
  sram_port_if.master mem
);

  logic prio_wr; // write wins the next tie
  logic sel_rd;
  logic sel_wr;
  logic conflict;

  assign conflict = rd.req && wr.req;
  assign sel_rd   = rd.req && (!wr.req || !prio_wr);
  assign sel_wr   = wr.req && !sel_rd;

  // last loser wins
  always_ff @(posedge aclk) begin
    if (areset) begin
      prio_wr <= 1'b0;
    end else if (conflict && mem.gnt) begin
      prio_wr <= sel_rd;
    end
  end

  assign mem.req   = rd.req || wr.req;
  assign mem.we    = sel_wr ? wr.we : rd.we;
  assign mem.index = sel_wr ? wr.index : rd.index;
  assign mem.wdata = sel_wr ? wr.wdata : rd.wdata;
  assign mem.strb  = sel_wr ? wr.strb : rd.strb;

  assign rd.gnt = sel_rd && mem.gnt;
  assign wr.gnt = sel_wr && mem.gnt;

  // only reads return data
  assign rd.rvalid = mem.rvalid;
  assign rd.rdata  = mem.rdata;
  assign wr.rvalid = 1'b0;
  assign wr.rdata  = '0;

  // a loser keeps req and is served next cycle
  a_rd_served_next: assert property (
    @(posedge aclk) disable iff (areset)
    rd.req && !rd.gnt |=> rd.gnt
  );

  a_wr_served_next: assert property (
    @(posedge aclk) disable iff (areset)
    wr.req && !wr.gnt |=> wr.gnt
  );

endmodule

`default_nettype wire

/* source/sram_port_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface sram_port_if;
  logic                  req;
  logic                  we;
  sram_pkg::sram_index_t index;
  sram_pkg::sram_word_t  wdata;
  sram_pkg::sram_strb_t  strb;
  logic                  gnt;
  logic                  rvalid; // SRAM_READ_CYCLE after a read grant
  sram_pkg::sram_word_t  rdata;

  modport master (output req, we, index, wdata, strb, input gnt, rvalid, rdata);
  modport slave (input req, we, index, wdata, strb, output gnt, rvalid, rdata);
  modport mem (input req, we, index, wdata, strb, output gnt, rvalid, rdata);
endinterface

`default_nettype wire
